//--- pfpu.f
verilog/pfpu_pkg.sv
verilog/pfpu_mem_if.sv
verilog/pfpu_ctlif.sv
verilog/pfpu_regf.sv
verilog/pfpu_prog.sv
verilog/pfpu_seq.sv
verilog/pfpu_top.sv
test/tb_clkgen.sv
test/pfpu_props.sv
test/tb_pfpu.sv

//--- run_sim.sh
#!/bin/sh
# Builds the vertex unit testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_pfpu -f pfpu.f

# The exit status of the pipeline is that of tee, so the log search decides.
./obj_dir/Vtb_pfpu | tee sim.log

if grep -q "Testbench passed" sim.log; then
	echo "run_sim: simulation ok"
	exit 0
fi
echo "run_sim: simulation did not pass, see sim.log"
exit 1

//--- test/pfpu_cases.txt
# w addr data writes a csr, r addr value reads and compares, x addr checks random data
# g starts a run, v addr x y expects a vertex, i expects the irq pulse, numbers are hex
# control registers keep only their implemented bits
w 0001 12345677
r 0001 12345670
w 0002 0000ffff
r 0002 0000007f
w 0003 ffffff81
r 0003 00000001
w 0004 ffffffff
r 0004 00000003
r 0401 00000000
# same offset in pages 1 and 2
w 0004 00000001
w 0205 a5a50001
w 0004 00000002
w 0205 5a5a0002
r 0205 5a5a0002
w 0004 00000001
r 0205 a5a50001
w 0004 00000000
# register file while idle
w 0104 00000064
w 0105 00000007
r 0104 00000064
r 0105 00000007
x 0110
x 017f
x 03ff
# mesh 3 by 2 at byte address 1000
w 0001 00001000
w 0002 00000002
w 0003 00000001
# r2 = r0 + r4, r3 = r1 - r5, r3 = r3 + r0, nop, vertex out
w 0200 40008004
w 0201 8000c085
w 0202 4000c180
w 0203 00000000
w 0204 c0000000
g
r 0100 00000000
v 200 00000064 fffffff9
v 201 00000065 fffffffa
v 202 00000066 fffffffb
v 203 00000064 fffffffa
v 204 00000065 fffffffb
v 205 00000066 fffffffc
i
r 0000 00000000
r 0005 00000006
w 0000 00000000
r 0005 00000000
r 0000 00000000
r 0100 00000002
r 0101 00000001

//--- test/pfpu_props.sv
// bound to pfpu_top and tapping its internal busy; checks are inactive while sys_rst is high.
`timescale 1ns/100ps

module pfpu_props
	import pfpu_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst,
	input logic [csr_aw-1:0] csr_a,
	input word_t csr_do,
	input logic irq,
	input logic busy,
	input logic vtx_stb
);

	logic csr_sel; // the unit is addressed in this cycle.

	assign csr_sel = csr_a[csr_sel_msb:csr_sel_lsb] == csr_base;

	// the interrupt is a single cycle pulse.
	irq_single: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq |=> !irq)
		else $error("irq was high in two consecutive cycles");

	// busy must already be low for a cycle when irq comes up.
	irq_after_run: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$rose(irq) |-> !busy && !$past(busy))
		else $error("irq rose before busy had fallen");

	stb_in_run: assert property (@(posedge sys_clk) disable iff (sys_rst)
		vtx_stb |-> busy) // vertices only come out of a run.
		else $error("vtx_stb was high while the unit was idle");

	// read data only follows a cycle that selected the unit.
	do_quiet: assert property (@(posedge sys_clk) disable iff (sys_rst)
		!$past(csr_sel) |-> csr_do == '0)
		else $error("csr_do was not zero after an unselected cycle");

endmodule

//--- test/tb_clkgen.sv
// 8 ns clock; active high reset covers the first 10 rising edges and drops on a falling edge.
`timescale 1ns/100ps

module tb_clkgen (
	output logic sys_clk,
	output logic sys_rst
);

	initial begin
		sys_clk = 1'b0; // first rising edge at 4 ns.
		forever #4 sys_clk = ~sys_clk; // half of the 8 ns period.
	end

	initial begin
		sys_rst = 1'b1; // synchronous reset held from time zero.
		repeat (10) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0; // released half a cycle away from the sampling edge.
	end

endmodule

//--- test/tb_pfpu.sv
// reads test/pfpu_cases.txt from the working directory; each command is a letter and hex numbers.
`timescale 1ns/100ps

module tb_pfpu
	import pfpu_pkg::*;
();

	localparam int wait_limit = 2000; // cycles allowed for any single wait.

	logic sys_clk;
	logic sys_rst;
	logic [csr_aw-1:0] csr_a;
	logic csr_we;
	word_t csr_di;
	word_t csr_do;
	logic irq;
	logic vtx_stb;
	dma_addr_t vtx_addr;
	word_t vtx_x;
	word_t vtx_y;
	int n_checks; // compares done, a run with none is not trusted.

	tb_clkgen u_clkgen (.sys_clk(sys_clk), .sys_rst(sys_rst));

	pfpu_top DUT (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.irq(irq),
		.vtx_stb(vtx_stb),
		.vtx_addr(vtx_addr),
		.vtx_x(vtx_x),
		.vtx_y(vtx_y)
	);

	bind pfpu_top pfpu_props u_props (.sys_clk(sys_clk), .sys_rst(sys_rst), .csr_a(csr_a),
		.csr_do(csr_do), .irq(irq), .busy(busy), .vtx_stb(vtx_stb));

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		n_checks++;
		if (got !== exp)
			abort_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_addr(input string name, input dma_addr_t got, input dma_addr_t exp);
		n_checks++;
		if (got !== exp)
			abort_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp)
			abort_run($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	// control register index placed in the unit's own window.
	function automatic logic [csr_aw-1:0] ctl_addr(input logic [3:0] idx);
		return {csr_base, 6'd0, idx};
	endfunction

	task automatic csr_write(input logic [csr_aw-1:0] a, input word_t d);
		@(negedge sys_clk);
		csr_a = a;
		csr_we = 1'b1;
		csr_di = d;
		@(negedge sys_clk);
		csr_we = 1'b0; // the write took effect on the edge between.
	endtask

	task automatic csr_read(input logic [csr_aw-1:0] a, output word_t d);
		@(negedge sys_clk);
		csr_a = a;
		csr_we = 1'b0;
		@(negedge sys_clk);
		d = csr_do; // read data belongs to the address of the previous cycle.
	endtask

	// reset changes on a falling edge, so it is looked at on the rising one.
	task automatic wait_reset();
		int cycles;
		cycles = 0;
		do begin
			@(posedge sys_clk);
			cycles++;
			if (cycles > wait_limit)
				abort_run("reset was never released");
		end while (sys_rst !== 1'b0);
	endtask

	task automatic random_readback(input logic [csr_aw-1:0] a);
		word_t d;
		word_t got;
		d = $urandom;
		csr_write(a, d);
		csr_read(a, got);
		check_word("csr_do", got, d);
	endtask

	// start the sequencer and poll the busy register until the core owns the register file.
	task automatic start_run();
		word_t status;
		int cycles;
		csr_write(ctl_addr(ctl_busy), 32'd1);
		cycles = 0;
		do begin
			csr_read(ctl_addr(ctl_busy), status);
			cycles++;
			if (cycles > wait_limit)
				abort_run("busy never rose after the start write");
		end while (status[0] !== 1'b1);
	endtask

	task automatic wait_vertex(input dma_addr_t exp_addr, input word_t exp_x, input word_t exp_y);
		int cycles;
		cycles = 0;
		do begin
			@(negedge sys_clk);
			cycles++;
			if (cycles > wait_limit)
				abort_run("no vertex strobe arrived within the timeout");
		end while (vtx_stb !== 1'b1);
		check_addr("vtx_addr", vtx_addr, exp_addr);
		check_word("vtx_x", vtx_x, exp_x);
		check_word("vtx_y", vtx_y, exp_y);
	endtask

	task automatic wait_irq();
		int cycles;
		cycles = 0;
		do begin
			@(negedge sys_clk);
			cycles++;
			if (cycles > wait_limit)
				abort_run("irq never came after the run");
		end while (irq !== 1'b1);
		@(negedge sys_clk);
		check_bit("irq", irq, 1'b0); // a pulse of exactly one cycle.
	endtask

	initial begin
		logic [8*8-1:0] cmd; // command letter, right aligned.
		logic [8*128-1:0] rest; // remainder of a comment line.
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		logic [31:0] arg_c;
		word_t got;
		int fd;
		int n;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		n_checks = 0;
		void'($urandom(32'h51bd_d9c6)); // one seed for the whole run.
		fd = $fopen("test/pfpu_cases.txt", "r");
		if (fd == 0)
			abort_run("cannot open test/pfpu_cases.txt");
		wait_reset();
		while ($fscanf(fd, "%s", cmd) == 1) begin
			case (cmd)
				"#": n = $fgets(rest, fd);
				"w": begin
					n = $fscanf(fd, "%h %h", arg_a, arg_b);
					if (n != 2)
						abort_run("a write line in the case file lacks its numbers");
					csr_write(arg_a[csr_aw-1:0], arg_b);
				end
				"r": begin
					n = $fscanf(fd, "%h %h", arg_a, arg_b);
					if (n != 2)
						abort_run("a read line in the case file lacks its numbers");
					csr_read(arg_a[csr_aw-1:0], got);
					check_word("csr_do", got, arg_b);
				end
				"x": begin
					n = $fscanf(fd, "%h", arg_a);
					if (n != 1)
						abort_run("a random readback line in the case file lacks its address");
					random_readback(arg_a[csr_aw-1:0]);
				end
				"g": start_run();
				"v": begin
					n = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
					if (n != 3)
						abort_run("a vertex line in the case file lacks its numbers");
					wait_vertex(arg_a[28:0], arg_b, arg_c);
				end
				"i": wait_irq();
				default: abort_run($sformatf("unknown command %0s in the case file", cmd));
			endcase
		end
		$fclose(fd);
		if (n_checks > 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			abort_run("the case file held no checks");
		end
	end

endmodule

//--- verilog/pfpu_ctlif.sv
// csr decoder; accesses take one cycle and read data comes back the cycle after the address.
`timescale 1ns/100ps

module pfpu_ctlif
	import pfpu_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst,
	input logic [csr_aw-1:0] csr_a,
	input logic csr_we,
	input word_t csr_di,
	output word_t csr_do,
	output logic irq,
	output logic start,
	output dma_addr_t dma_base,
	output mesh_t hmesh_last,
	output mesh_t vmesh_last,
	input logic busy,
	input logic vnext,
	input prog_addr_t pc,
	pfpu_mem_if.master regf_csr,
	pfpu_mem_if.master prog_csr
);

	logic csr_sel; // this unit is addressed.
	logic win_regf; // register file window.
	logic win_prog; // program memory window.
	logic win_cont; // control register window.
	logic old_busy; // busy one cycle ago, for the falling edge.
	logic [1:0] cp_page; // upper program address bits for csr access.
	logic [vcount_w-1:0] vertex_counter;
	word_t csr_do_r; // control register read data.
	logic csr_do_cont; // one-hot read source select, registered with the address.
	logic csr_do_regf;
	logic csr_do_prog;

	assign csr_sel = csr_a[csr_sel_msb:csr_sel_lsb] == csr_base;
	assign win_prog = csr_a[prog_sel_bit]; // program memory has priority.
	assign win_regf = csr_a[regf_sel_bit] & ~csr_a[prog_sel_bit];
	assign win_cont = ~csr_a[regf_sel_bit] & ~csr_a[prog_sel_bit];

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			old_busy <= 1'b0;
			irq <= 1'b0;
			start <= 1'b0;
			dma_base <= '0;
			hmesh_last <= '0;
			vmesh_last <= '0;
			cp_page <= '0;
			vertex_counter <= '0;
			csr_do_cont <= 1'b0;
			csr_do_regf <= 1'b0;
			csr_do_prog <= 1'b0;
		end else begin
			old_busy <= busy;
			irq <= old_busy & ~busy; // one pulse after the run ends.
			start <= 1'b0; // start is a single cycle strobe.
			if (vnext)
				vertex_counter <= vertex_counter + 1'b1; // one count per vertex.
			csr_do_cont <= csr_sel & win_cont; // enables travel with the memory reads.
			csr_do_regf <= csr_sel & win_regf;
			csr_do_prog <= csr_sel & win_prog;
			if (csr_sel & win_cont & csr_we) begin
				case (csr_a[3:0])
					ctl_busy: begin
						start <= csr_di[0]; // writing 0 only clears the counter.
						vertex_counter <= '0; // cleared by any write here.
					end
					ctl_dma_base: dma_base <= csr_di[31:3]; // 8 byte aligned.
					ctl_hmesh: hmesh_last <= csr_di[6:0];
					ctl_vmesh: vmesh_last <= csr_di[6:0];
					ctl_page: cp_page <= csr_di[1:0];
					default: ; // other indices are read only or unused.
				endcase
			end
		end
	end

	// control register read data, captured with the address like a memory read.
	always_ff @(posedge sys_clk) begin
		case (csr_a[3:0])
			ctl_busy: csr_do_r <= word_t'(busy);
			ctl_dma_base: csr_do_r <= {dma_base, 3'b000};
			ctl_hmesh: csr_do_r <= word_t'(hmesh_last);
			ctl_vmesh: csr_do_r <= word_t'(vmesh_last);
			ctl_page: csr_do_r <= word_t'(cp_page);
			ctl_vcount: csr_do_r <= word_t'(vertex_counter);
			ctl_pc: csr_do_r <= word_t'(pc);
			default: csr_do_r <= '0; // unused indices read as zero.
		endcase
	end

	// the one-hot registered enables pick the source of the read data.
	assign csr_do = ({32{csr_do_cont}} & csr_do_r)
		| ({32{csr_do_regf}} & regf_csr.rdata)
		| ({32{csr_do_prog}} & prog_csr.rdata);

	assign regf_csr.addr = csr_a[regf_aw-1:0]; // word index inside the window.
	assign regf_csr.wdata = csr_di;
	assign regf_csr.we = csr_sel & win_regf & csr_we; // dropped by pfpu_regf while busy.

	assign prog_csr.addr = {cp_page, csr_a[page_aw-1:0]}; // page selects one quarter.
	assign prog_csr.wdata = csr_di;
	assign prog_csr.we = csr_sel & win_prog & csr_we; // host must not write while busy.

endmodule

//--- verilog/pfpu_mem_if.sv
// one synchronous-read memory port; read data is valid the cycle after the address.
`timescale 1ns/100ps

interface pfpu_mem_if
	import pfpu_pkg::*;
#(
	parameter int aw = regf_aw // address width of the memory behind this port.
) ();

	logic [aw-1:0] addr; // word address, sampled at the clock edge.
	word_t wdata; // data to store when we is high.
	logic we; // write strobe, one word per cycle.
	word_t rdata; // word at the address of the previous cycle.

	// the requester drives address and write side.
	modport master (
		output addr,
		output wdata,
		output we,
		input rdata
	);

	// the memory answers with read data.
	modport slave (
		input addr,
		input wdata,
		input we,
		output rdata
	);

endinterface

//--- verilog/pfpu_pkg.sv
// csr map, instruction fields and sizes; one unit per 1 KiB csr window, integer datapath only.
package pfpu_pkg;

	localparam int csr_aw = 14; // width of the csr address bus.
	localparam int csr_sel_msb = 13; // unit select field, upper end.
	localparam int csr_sel_lsb = 10; // unit select field, lower end.
	localparam logic [3:0] csr_base = 4'h0; // value the select field must carry.
	localparam int regf_sel_bit = 8; // set for the register file window.
	localparam int prog_sel_bit = 9; // set for the program memory window, wins over bit 8.

	localparam logic [3:0] ctl_busy = 4'd0; // write bit 0 to start, read gives busy.
	localparam logic [3:0] ctl_dma_base = 4'd1; // byte address, lower 3 bits dropped.
	localparam logic [3:0] ctl_hmesh = 4'd2; // last horizontal index.
	localparam logic [3:0] ctl_vmesh = 4'd3; // last vertical index.
	localparam logic [3:0] ctl_page = 4'd4; // program memory page for csr access.
	localparam logic [3:0] ctl_vcount = 4'd5; // vertices emitted since the last start write.
	localparam logic [3:0] ctl_pc = 4'd9; // sequencer program counter, read only.

	localparam int regf_depth = 128; // words in the register file.
	localparam int regf_aw = 7; // register file address width.
	localparam int prog_depth = 2048; // words in the program memory.
	localparam int prog_aw = 11; // program memory address width.
	localparam int page_aw = 9; // offset inside one 512 word page.
	localparam int vcount_w = 14; // width of the vertex counter.

	localparam logic [1:0] op_nop = 2'd0; // only advances pc.
	localparam logic [1:0] op_add = 2'd1; // dst = a + b.
	localparam logic [1:0] op_sub = 2'd2; // dst = a - b.
	localparam logic [1:0] op_vout = 2'd3; // emit registers 2 and 3, go to the next point.

	localparam int f_op_msb = 31; // opcode field.
	localparam int f_op_lsb = 30;
	localparam int f_dst_msb = 20; // destination register.
	localparam int f_dst_lsb = 14;
	localparam int f_a_msb = 13; // first source register.
	localparam int f_a_lsb = 7;
	localparam int f_b_msb = 6; // second source register.
	localparam int f_b_lsb = 0;

	typedef logic [31:0] word_t; // data word in both memories.
	typedef logic [regf_aw-1:0] regf_addr_t;
	typedef logic [prog_aw-1:0] prog_addr_t;
	typedef logic [6:0] mesh_t; // mesh index, so at most 128 points per axis.
	typedef logic [28:0] dma_addr_t; // address in units of 8 bytes.

endpackage

//--- verilog/pfpu_prog.sv
// 2048 word program memory; csr port reads and writes, core port only fetches, both registered.
`timescale 1ns/100ps

module pfpu_prog
	import pfpu_pkg::*;
(
	input logic sys_clk,
	pfpu_mem_if.slave prog_csr,
	pfpu_mem_if.slave prog_core
);

	word_t mem [prog_depth]; // four pages of 512 instructions.
	word_t csr_q; // csr read data.
	word_t core_q; // fetched instruction.

	always_ff @(posedge sys_clk) begin
		if (prog_csr.we)
			mem[prog_csr.addr] <= prog_csr.wdata; // only the host stores programs.
		csr_q <= mem[prog_csr.addr];
	end

	// second read port for the sequencer fetch.
	always_ff @(posedge sys_clk) begin
		core_q <= mem[prog_core.addr];
	end

	assign prog_csr.rdata = csr_q;
	assign prog_core.rdata = core_q;

endmodule

//--- verilog/pfpu_regf.sv
// 128 word register file with one shared port; the sequencer owns it while busy is high.
`timescale 1ns/100ps

module pfpu_regf
	import pfpu_pkg::*;
(
	input logic sys_clk,
	input logic busy,
	pfpu_mem_if.slave regf_csr,
	pfpu_mem_if.slave regf_core
);

	word_t mem [regf_depth]; // the registers, no reset.
	regf_addr_t addr; // address of the selected port.
	word_t wdata;
	logic we;
	word_t rd_q; // synchronous read data.
	logic core_q; // the read in rd_q belongs to the sequencer.

	// busy picks the owner of the single port.
	always_comb begin
		if (busy) begin
			addr = regf_core.addr;
			wdata = regf_core.wdata;
			we = regf_core.we;
		end else begin
			addr = regf_csr.addr;
			wdata = regf_csr.wdata;
			we = regf_csr.we;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (we)
			mem[addr] <= wdata;
		rd_q <= mem[addr]; // old contents on a same-cycle write.
		core_q <= busy; // remembers who issued this read.
	end

	assign regf_core.rdata = core_q ? rd_q : '0; // the other port sees zero.
	assign regf_csr.rdata = core_q ? '0 : rd_q;

endmodule

//--- verilog/pfpu_seq.sv
// mesh walker and sequencer; each point must end in a vertex output, or the run never ends.
`timescale 1ns/100ps

module pfpu_seq
	import pfpu_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst,
	input logic start,
	input dma_addr_t dma_base,
	input mesh_t hmesh_last,
	input mesh_t vmesh_last,
	output logic busy,
	output logic vnext,
	output prog_addr_t pc,
	output logic vtx_stb,
	output dma_addr_t vtx_addr,
	output word_t vtx_x,
	output word_t vtx_y,
	pfpu_mem_if.master regf_core,
	pfpu_mem_if.master prog_core
);

	typedef enum logic [3:0] {
		s_idle,
		s_load_h, // write h to register 0.
		s_load_v, // write v to register 1.
		s_fetch, // pc on the program memory.
		s_decode, // instruction arrives, source a or register 2 addressed.
		s_read_b, // source b addressed.
		s_write, // result written to dst.
		s_vout, // register 3 addressed, vertex strobe set up.
		s_done // last strobe still out, busy held.
	} state_t;

	state_t state;
	mesh_t h; // inner loop index.
	mesh_t v; // outer loop index.
	dma_addr_t addr_cnt; // address of the next vertex.
	word_t instr; // current instruction.
	word_t opa; // first operand.
	logic [1:0] op; // opcode of the arriving instruction.

	assign op = prog_core.rdata[f_op_msb:f_op_lsb];
	assign busy = state != s_idle; // stays up through s_done.
	assign vnext = vtx_stb; // one vertex per mesh point.
	assign vtx_y = regf_core.rdata; // register 3 lands in the strobe cycle.

	assign prog_core.addr = pc;
	assign prog_core.wdata = '0;
	assign prog_core.we = 1'b0; // fetch only.

	always_comb begin
		regf_core.addr = '0;
		regf_core.wdata = '0;
		regf_core.we = 1'b0;
		case (state)
			s_load_h: begin
				regf_core.addr = regf_addr_t'(0);
				regf_core.wdata = word_t'(h);
				regf_core.we = 1'b1;
			end
			s_load_v: begin
				regf_core.addr = regf_addr_t'(1);
				regf_core.wdata = word_t'(v);
				regf_core.we = 1'b1;
			end
			s_decode: begin
				if (op == op_vout)
					regf_core.addr = regf_addr_t'(2); // x coordinate.
				else
					regf_core.addr = prog_core.rdata[f_a_msb:f_a_lsb];
			end
			s_read_b: regf_core.addr = instr[f_b_msb:f_b_lsb];
			s_write: begin
				regf_core.addr = instr[f_dst_msb:f_dst_lsb];
				if (instr[f_op_msb:f_op_lsb] == op_sub)
					regf_core.wdata = opa - regf_core.rdata;
				else
					regf_core.wdata = opa + regf_core.rdata;
				regf_core.we = 1'b1;
			end
			s_vout: regf_core.addr = regf_addr_t'(3); // y coordinate.
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= s_idle;
			h <= '0;
			v <= '0;
			pc <= '0;
			vtx_stb <= 1'b0;
		end else begin
			vtx_stb <= 1'b0;
			case (state)
				s_idle: if (start) begin
					h <= '0;
					v <= '0;
					state <= s_load_h;
				end
				s_load_h: state <= s_load_v;
				s_load_v: begin
					pc <= '0; // every point runs the program from the top.
					state <= s_fetch;
				end
				s_fetch: state <= s_decode;
				s_decode: begin
					case (op)
						op_nop: begin
							pc <= pc + 1'b1;
							state <= s_fetch;
						end
						op_vout: state <= s_vout;
						default: state <= s_read_b;
					endcase
				end
				s_read_b: state <= s_write;
				s_write: begin
					pc <= pc + 1'b1;
					state <= s_fetch;
				end
				s_vout: begin
					vtx_stb <= 1'b1;
					if (h != hmesh_last) begin
						h <= h + 1'b1;
						state <= s_load_h;
					end else if (v != vmesh_last) begin
						h <= '0;
						v <= v + 1'b1;
						state <= s_load_h;
					end else begin
						h <= '0; // the last indices remain in registers 0 and 1.
						state <= s_done;
					end
				end
				s_done: state <= s_idle;
				default: state <= s_idle;
			endcase
		end
	end

	// payload side of the walk.
	always_ff @(posedge sys_clk) begin
		if (state == s_idle)
			addr_cnt <= dma_base; // first vertex goes to the base.
		if (state == s_decode)
			instr <= prog_core.rdata;
		if (state == s_read_b)
			opa <= regf_core.rdata;
		if (state == s_vout) begin
			vtx_x <= regf_core.rdata;
			vtx_addr <= addr_cnt;
			addr_cnt <= addr_cnt + 1'b1; // one slot per mesh point.
		end
	end

endmodule

//--- verilog/pfpu_top.sv
// vertex unit top; vertices leave on a strobe without back-pressure, irq marks the end of a run.
`timescale 1ns/100ps

module pfpu_top
	import pfpu_pkg::*;
(
	input logic sys_clk,
	input logic sys_rst,
	input logic [csr_aw-1:0] csr_a,
	input logic csr_we,
	input word_t csr_di,
	output word_t csr_do,
	output logic irq,
	output logic vtx_stb,
	output dma_addr_t vtx_addr,
	output word_t vtx_x,
	output word_t vtx_y
);

	logic start; // run request from the csr side.
	logic busy; // sequencer owns the register file.
	logic vnext; // one vertex emitted.
	prog_addr_t pc;
	dma_addr_t dma_base;
	mesh_t hmesh_last;
	mesh_t vmesh_last;

	pfpu_mem_if #(.aw(regf_aw)) regf_csr ();
	pfpu_mem_if #(.aw(regf_aw)) regf_core ();
	pfpu_mem_if #(.aw(prog_aw)) prog_csr ();
	pfpu_mem_if #(.aw(prog_aw)) prog_core ();

	pfpu_ctlif u_ctlif (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a(csr_a),
		.csr_we(csr_we),
		.csr_di(csr_di),
		.csr_do(csr_do),
		.irq(irq),
		.start(start),
		.dma_base(dma_base),
		.hmesh_last(hmesh_last),
		.vmesh_last(vmesh_last),
		.busy(busy),
		.vnext(vnext),
		.pc(pc),
		.regf_csr(regf_csr.master),
		.prog_csr(prog_csr.master)
	);

	pfpu_regf u_regf (
		.sys_clk(sys_clk),
		.busy(busy),
		.regf_csr(regf_csr.slave),
		.regf_core(regf_core.slave)
	);

	pfpu_prog u_prog (
		.sys_clk(sys_clk),
		.prog_csr(prog_csr.slave),
		.prog_core(prog_core.slave)
	);

	pfpu_seq u_seq (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.start(start),
		.dma_base(dma_base),
		.hmesh_last(hmesh_last),
		.vmesh_last(vmesh_last),
		.busy(busy),
		.vnext(vnext),
		.pc(pc),
		.vtx_stb(vtx_stb),
		.vtx_addr(vtx_addr),
		.vtx_x(vtx_x),
		.vtx_y(vtx_y),
		.regf_core(regf_core.master),
		.prog_core(prog_core.master)
	);

endmodule
